// ==== mem_bus_pkg.sv ====
`default_nettype none

// fetch bus shared by the core side and the backing memory side of the ITIM.
package mem_bus_pkg;

  // one fetch request, 71 bits.
  typedef struct packed {
    logic        valid;
    logic        fence;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // one response, 33 bits.
  // rdata only carries meaning while ready is high.
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== itim_pkg.sv ====
`default_nettype none

package itim_pkg;

  // back state of the ITIM controller.
  typedef enum logic [2:0] {
    st_hit,
    st_miss,
    st_load,
    st_update,
    st_fence
  } itim_state_t;

  // classification of the request under lookup.
  typedef enum logic [1:0] {
    out_hit,
    out_miss,
    out_bypass,
    out_fence
  } itim_outcome_t;

endpackage

`default_nettype wire

// ==== itim_ram.sv ====
`default_nettype none

module itim_ram #(
  parameter int DATA_BITS = 32,
  parameter int ADDR_BITS = 4
) (
  input  logic                 clk,
  input  logic                 wen,
  input  logic [ADDR_BITS-1:0] waddr,
  input  logic [DATA_BITS-1:0] wdata,
  input  logic [ADDR_BITS-1:0] raddr,
  output logic [DATA_BITS-1:0] rdata
);

  logic [DATA_BITS-1:0] mem [2**ADDR_BITS] = '{default: '0};
  logic [DATA_BITS-1:0] rdata_q = '0;

  // a read and a write to the same entry at one edge returns the old entry.
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata_q <= mem[raddr];
  end

  assign rdata = rdata_q;

endmodule

`default_nettype wire

// ==== itim_ctrl.sv ====
`default_nettype none

module itim_ctrl
  import mem_bus_pkg::*;
  import itim_pkg::*;
#(
  parameter int          DEPTH     = 4,
  parameter int          WIDTH     = 2,
  parameter logic [31:0] BASE_ADDR = 32'h0000_1000,
  parameter logic [31:0] TOP_ADDR  = 32'h0000_2000
) (
  input  logic                             clk,
  input  logic                             rst,
  input  mem_req_t                         req,
  output mem_rsp_t                         rsp,
  output mem_req_t                         mem_req,
  input  mem_rsp_t                         mem_rsp,
  input  logic [29-DEPTH-WIDTH:0]          tag_rdata,
  input  logic [32*(2**WIDTH)-1:0]         line_rdata,
  input  logic                             lock_rdata,
  output logic [DEPTH-1:0]                 array_raddr,
  output logic                             array_wen,
  output logic [DEPTH-1:0]                 array_waddr,
  output logic [29-DEPTH-WIDTH:0]          tag_wdata,
  output logic [32*(2**WIDTH)-1:0]         line_wdata,
  output logic                             lock_wen,
  output logic                             lock_wdata
);

  localparam int TAG_BITS  = 30 - DEPTH - WIDTH;
  localparam int LINE_BITS = 32 * (2**WIDTH);
  localparam int IDX_LSB   = WIDTH + 2;
  localparam int TAG_LSB   = DEPTH + WIDTH + 2;

  // **************************************************
  // front register
  // **************************************************

  logic                f_en;
  logic                f_fence;
  logic [31:0]         f_addr;
  logic [TAG_BITS-1:0] f_tag;
  logic [DEPTH-1:0]    f_idx;
  logic [WIDTH-1:0]    f_word;

  always_ff @(posedge clk) begin
    if (!rst) begin
      f_en    <= 1'b0;
      f_fence <= 1'b0;
    end else begin
      f_en    <= req.valid & ~req.fence;
      f_fence <= req.valid & req.fence;
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid && !req.fence) begin
      f_addr <= req.addr;
    end
  end

  assign f_tag  = f_addr[31:TAG_LSB];
  assign f_idx  = f_addr[IDX_LSB +: DEPTH];
  assign f_word = f_addr[2 +: WIDTH];

  // **************************************************
  // lookup
  // **************************************************

  itim_state_t         state;
  itim_state_t         state_d;
  itim_outcome_t       outcome;
  logic                in_window;
  logic [WIDTH-1:0]    cnt;
  logic [WIDTH-1:0]    cnt_d;
  logic [DEPTH-1:0]    fidx;
  logic [DEPTH-1:0]    fidx_d;
  logic [LINE_BITS-1:0] line_q;
  logic [LINE_BITS-1:0] line_d;
  logic                fill;
  logic                bypass;
  logic [31:0]         fill_addr;

  assign in_window = (f_addr >= BASE_ADDR) && (f_addr < TOP_ADDR);

  // the arrays were read at the request edge, so tag and lock are valid now.
  always_comb begin
    if (f_fence) begin
      outcome = out_fence;
    end else if (!in_window) begin
      outcome = out_bypass;
    end else if (!lock_rdata) begin
      outcome = out_miss;
    end else if (tag_rdata != f_tag) begin
      // a locked line is never replaced.
      outcome = out_bypass;
    end else begin
      outcome = out_hit;
    end
  end

  // **************************************************
  // back state machine
  // **************************************************

  always_comb begin
    state_d   = state;
    cnt_d     = cnt;
    fidx_d    = fidx;
    line_d    = line_q;
    fill      = 1'b0;
    bypass    = 1'b0;
    rsp.ready = 1'b0;
    rsp.rdata = '0;

    case (state)
      st_hit: begin
        if (f_en || f_fence) begin
          case (outcome)
            out_hit: begin
              rsp.ready = 1'b1;
              rsp.rdata = line_rdata[32*f_word +: 32];
            end
            out_miss: begin
              fill = 1'b1;
            end
            out_bypass: begin
              bypass = 1'b1;
            end
            default: begin
              state_d = st_fence;
              fidx_d  = '0;
            end
          endcase
        end
      end
      st_miss: begin
        fill = 1'b1;
      end
      st_load: begin
        bypass = 1'b1;
      end
      st_update: begin
        // the line is written in this cycle and the fetched word returned.
        rsp.ready = 1'b1;
        rsp.rdata = line_q[32*f_word +: 32];
        state_d   = st_hit;
      end
      st_fence: begin
        if (fidx == '1) begin
          rsp.ready = 1'b1;
          state_d   = st_hit;
        end else begin
          fidx_d = fidx + 1'b1;
        end
      end
      default: begin
        state_d = st_hit;
      end
    endcase

    // line fill, one word per ready cycle. cnt wraps back to zero at the end.
    if (fill) begin
      state_d = st_miss;
      if (mem_rsp.ready) begin
        line_d[32*cnt +: 32] = mem_rsp.rdata;
        cnt_d = cnt + 1'b1;
        if (cnt == '1) begin
          state_d = st_update;
        end
      end
    end

    // single word passed straight through from backing memory.
    if (bypass) begin
      rsp.ready = mem_rsp.ready;
      rsp.rdata = mem_rsp.rdata;
      state_d   = mem_rsp.ready ? st_hit : st_load;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_hit;
      cnt   <= '0;
      fidx  <= '0;
    end else begin
      state <= state_d;
      cnt   <= cnt_d;
      fidx  <= fidx_d;
    end
  end

  always_ff @(posedge clk) begin
    line_q <= line_d;
  end

  // **************************************************
  // backing memory request
  // **************************************************

  assign fill_addr = {f_addr[31:IDX_LSB], cnt, 2'b00};

  always_comb begin
    mem_req       = '0;
    mem_req.valid = fill | bypass;
    mem_req.instr = 1'b1;
    mem_req.addr  = fill ? fill_addr : f_addr;
  end

  // **************************************************
  // array ports
  // **************************************************

  // while idle the arrays follow the incoming address so that the lookup
  // data is ready in the cycle after the request.
  assign array_raddr = (state == st_fence) ? fidx : req.addr[IDX_LSB +: DEPTH];
  assign array_waddr = (state == st_fence) ? fidx : f_idx;

  assign array_wen  = (state == st_update);
  assign tag_wdata  = f_tag;
  assign line_wdata = line_q;

  // a fill sets the lock bit and the fence walk clears it.
  assign lock_wen   = (state == st_update) || (state == st_fence);
  assign lock_wdata = (state == st_update);

endmodule

`default_nettype wire

// ==== itim.sv ====
`default_nettype none

module itim
  import mem_bus_pkg::*;
#(
  parameter int          DEPTH     = 4,
  parameter int          WIDTH     = 2,
  parameter logic [31:0] BASE_ADDR = 32'h0000_1000,
  parameter logic [31:0] TOP_ADDR  = 32'h0000_2000,
  parameter bit          ENABLE    = 1'b1
) (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t req,
  output mem_rsp_t rsp,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  localparam int TAG_BITS  = 30 - DEPTH - WIDTH;
  localparam int LINE_BITS = 32 * (2**WIDTH);

  if (ENABLE) begin : g_itim

    logic [TAG_BITS-1:0]  tag_rdata;
    logic [LINE_BITS-1:0] line_rdata;
    logic                 lock_rdata;
    logic [DEPTH-1:0]     array_raddr;
    logic                 array_wen;
    logic [DEPTH-1:0]     array_waddr;
    logic [TAG_BITS-1:0]  tag_wdata;
    logic [LINE_BITS-1:0] line_wdata;
    logic                 lock_wen;
    logic                 lock_wdata;

    // tag, line and lock arrays share one read and one write index.
    itim_ram #(.DATA_BITS(TAG_BITS), .ADDR_BITS(DEPTH)) tag_ram (
      .clk   (clk),
      .wen   (array_wen),
      .waddr (array_waddr),
      .wdata (tag_wdata),
      .raddr (array_raddr),
      .rdata (tag_rdata)
    );

    itim_ram #(.DATA_BITS(LINE_BITS), .ADDR_BITS(DEPTH)) line_ram (
      .clk   (clk),
      .wen   (array_wen),
      .waddr (array_waddr),
      .wdata (line_wdata),
      .raddr (array_raddr),
      .rdata (line_rdata)
    );

    itim_ram #(.DATA_BITS(1), .ADDR_BITS(DEPTH)) lock_ram (
      .clk   (clk),
      .wen   (lock_wen),
      .waddr (array_waddr),
      .wdata (lock_wdata),
      .raddr (array_raddr),
      .rdata (lock_rdata)
    );

    itim_ctrl #(
      .DEPTH     (DEPTH),
      .WIDTH     (WIDTH),
      .BASE_ADDR (BASE_ADDR),
      .TOP_ADDR  (TOP_ADDR)
    ) ctrl (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .rsp         (rsp),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp),
      .tag_rdata   (tag_rdata),
      .line_rdata  (line_rdata),
      .lock_rdata  (lock_rdata),
      .array_raddr (array_raddr),
      .array_wen   (array_wen),
      .array_waddr (array_waddr),
      .tag_wdata   (tag_wdata),
      .line_wdata  (line_wdata),
      .lock_wen    (lock_wen),
      .lock_wdata  (lock_wdata)
    );

  end else begin : g_pass

    // without the ITIM every fetch goes straight to backing memory.
    assign mem_req = req;
    assign rsp     = mem_rsp;

  end

endmodule

`default_nettype wire

// ==== imem_model.sv ====
`default_nettype none

module imem_model
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  mem_rsp_t rsp_q = '0;
  int       waits = 0;
  logic     armed = 1'b0;

  // contents of backing memory at a byte address.
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return {addr[24:0], addr[31:25]} ^ 32'ha5a5a5a5;
  endfunction

  // each word is answered after 0 to 3 wait cycles, and ready lasts one cycle.
  // the response changes on the falling edge, so the DUT sees it settled.
  always @(negedge clk) begin
    rsp_q.ready = 1'b0;
    rsp_q.rdata = '0;
    if (!rst) begin
      armed = 1'b0;
    end else if (mem_req.valid) begin
      if (!armed) begin
        waits = $urandom % 4;
        armed = 1'b1;
      end
      if (waits == 0) begin
        rsp_q.ready = 1'b1;
        rsp_q.rdata = word_at(mem_req.addr);
        armed       = 1'b0;
      end else begin
        waits = waits - 1;
      end
    end
  end

  assign mem_rsp = rsp_q;

endmodule

`default_nettype wire

// ==== tb_itim.sv ====
`default_nettype none

module tb_itim
  import mem_bus_pkg::*;
  import itim_pkg::*;
();

  localparam int          DEPTH      = 4;
  localparam int          WIDTH      = 2;
  localparam int          LINE_WORDS = 2**WIDTH;
  localparam logic [31:0] BASE_ADDR  = 32'h0000_1000;
  localparam logic [31:0] TOP_ADDR   = 32'h0000_2000;
  localparam int          N_REQ      = 300;
  // a conflict adds one refetch, and each backing word waits up to 4 cycles.
  localparam int          MAX_CYCLES = 2 * N_REQ * (2**DEPTH + 4 * LINE_WORDS) + 200;

  logic     clk = 1'b0;
  logic     rst;
  mem_req_t req;
  mem_rsp_t rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  logic        lock_q [2**DEPTH];
  logic [31:0] tag_q  [2**DEPTH];
  logic [31:0] words  [$];
  int          valid_cycles;
  int          errors;
  int          n_hit;
  int          n_miss;
  int          n_bypass;
  int          n_fence;

  always #50 clk = ~clk;

  itim #(
    .DEPTH     (DEPTH),
    .WIDTH     (WIDTH),
    .BASE_ADDR (BASE_ADDR),
    .TOP_ADDR  (TOP_ADDR),
    .ENABLE    (1'b1)
  ) dut (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .rsp     (rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  imem_model imem (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  // records every word that backing memory completes and checks the fixed request fields.
  always @(posedge clk) begin
    if (rst && mem_req.valid) begin
      valid_cycles++;
      assert (mem_req.instr && !mem_req.fence && mem_req.wstrb == '0)
        else report_mismatch("request flags", mem_req.addr,
                             {mem_req.instr, mem_req.fence, mem_req.wstrb}, 32'h20);
      assert (mem_req.wdata == '0)
        else report_mismatch("request wdata", mem_req.addr, mem_req.wdata, 0);
      if (mem_rsp.ready) begin
        words.push_back(mem_req.addr);
      end
    end
  end

  // **************************************************
  // reference model
  // **************************************************

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[24:0], addr[31:25]} ^ 32'ha5a5a5a5;
  endfunction

  // mostly a few lines in the window, so hits and conflicts both occur.
  function automatic logic [31:0] random_addr();
    int r;
    r = $urandom % 100;
    if (r < 8) begin
      return $urandom & 32'h0000_0ffc;
    end else if (r < 16) begin
      return 32'h0000_4000 | ($urandom & 32'h0000_0ffc);
    end
    return ((32'h10 + $urandom % 3) << 8) | (($urandom % 4) << 4) | (($urandom % 4) << 2);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] addr,
                                 input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("mismatch at %0t: %s addr %h got %h expected %h (state %s)", $time, what,
             addr, got, exp, dut.g_itim.ctrl.state.name());
  endtask

  // called at a falling edge, and returns at the falling edge after the response.
  task automatic run_request(input logic fence, input logic [31:0] addr,
                             output int lat, output logic [31:0] data);
    words.delete();
    valid_cycles = 0;
    req.valid    = 1'b1;
    req.fence    = fence;
    req.addr     = addr;
    @(posedge clk);
    @(negedge clk);
    req.valid = 1'b0;
    req.fence = 1'b0;
    lat       = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!rsp.ready);
    data = rsp.rdata;
    @(negedge clk);
  endtask

  task automatic fetch(input logic [31:0] addr, output logic conflict);
    int          lat;
    int          idx;
    logic [31:0] tag;
    logic [31:0] base;
    logic [31:0] data;
    logic        in_window;
    logic        ok;
    idx       = int'(addr[WIDTH+2 +: DEPTH]);
    tag       = addr >> (DEPTH + WIDTH + 2);
    base      = addr & ~32'(LINE_WORDS * 4 - 1);
    in_window = (addr >= BASE_ADDR) && (addr < TOP_ADDR);
    conflict  = in_window && lock_q[idx] && (tag_q[idx] != tag);
    run_request(1'b0, addr, lat, data);
    assert (data == expected_word(addr))
      else report_mismatch("read data", addr, data, expected_word(addr));
    if (!in_window || conflict) begin
      n_bypass++;
      ok = (words.size() == 1);
      if (ok) begin
        ok = (words[0] == addr);
      end
      assert (ok) else report_mismatch("bypass read", addr, words.size(), 1);
    end else if (!lock_q[idx]) begin
      n_miss++;
      ok = (words.size() == LINE_WORDS);
      foreach (words[i]) begin
        ok = ok && (words[i] == base + 4 * i);
      end
      assert (ok) else report_mismatch("line fill", addr, words.size(), LINE_WORDS);
      lock_q[idx] = 1'b1;
      tag_q[idx]  = tag;
    end else begin
      n_hit++;
      assert (lat == 1 && valid_cycles == 0)
        else report_mismatch("hit latency", addr, lat, 1);
    end
  endtask

  task automatic fence_all();
    int          lat;
    logic [31:0] data;
    run_request(1'b1, 32'h0, lat, data);
    n_fence++;
    assert (valid_cycles == 0) else report_mismatch("fence traffic", 0, valid_cycles, 0);
    foreach (lock_q[i]) begin
      lock_q[i] = 1'b0;
    end
  endtask

  // **************************************************
  // stimulus
  // **************************************************

  initial begin
    logic [31:0] addr;
    logic        conflict;
    int          idx;
    void'($urandom(32'he388));
    rst       = 1'b0;
    req       = '0;
    req.instr = 1'b1;
    errors    = 0;
    n_hit     = 0;
    n_miss    = 0;
    n_bypass  = 0;
    n_fence   = 0;
    foreach (lock_q[i]) begin
      lock_q[i] = 1'b0;
      tag_q[i]  = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    repeat (4) begin
      @(posedge clk);
      assert (!rsp.ready && !mem_req.valid)
        else report_mismatch("idle after reset", 0, {rsp.ready, mem_req.valid}, 0);
    end
    @(negedge clk);
    for (int i = 0; i < N_REQ; i++) begin
      if ($urandom % 100 < 5) begin
        fence_all();
      end else begin
        addr = random_addr();
        fetch(addr, conflict);
        // the locked line must survive the conflicting fetch.
        if (conflict) begin
          idx = int'(addr[WIDTH+2 +: DEPTH]);
          fetch((tag_q[idx] << (DEPTH + WIDTH + 2)) | (addr & 32'h0000_00ff), conflict);
        end
      end
    end
    assert (n_hit > 0 && n_miss > 0 && n_bypass > 0 && n_fence > 0) else begin
      errors++;
      $display("stimulus did not produce every kind of request");
    end
    $display("errors: %0d (hits %0d, misses %0d, bypasses %0d, fences %0d)", errors,
             n_hit, n_miss, n_bypass, n_fence);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(MAX_CYCLES * 100);
    $display("timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
mem_bus_pkg.sv
itim_pkg.sv
itim_ram.sv
itim_ctrl.sv
itim.sv
imem_model.sv
tb_itim.sv

// ==== Bender.yml ====
package:
  name: itim

sources:
  - files:
      - mem_bus_pkg.sv
      - itim_pkg.sv
      - itim_ram.sv
      - itim_ctrl.sv
      - itim.sv
  - target: test
    files:
      - imem_model.sv
      - tb_itim.sv
